//--- logic/cpu_types_pkg.sv
// CPU-wide types
// Address, data and reorder-buffer widths shared by every unit of the core,
// plus the memory access size code
`default_nettype none

package cpu_types_pkg;

	// Reorder buffer depth and the index that selects one of its entries
	localparam int ROB_ENTRIES = 32;
	typedef logic [$clog2(ROB_ENTRIES)-1:0] rob_ndx_t;

	// Virtual and physical byte addresses
	typedef logic [31:0] vaddr_t;
	typedef logic [31:0] paddr_t;

	// Pages are 4 kB, so the low 12 address bits pass through translation
	localparam int PAGE_OFS_W = 12;
	typedef logic [$bits(paddr_t)-PAGE_OFS_W-1:0] ppn_t;

	// One data word as moved between registers and memory
	typedef logic [63:0] value_t;

	// Access size, encoded as log2 of the byte count
	// A hexi access is too wide to be kept as cached load data
	typedef enum logic [2:0] {
		byt,
		wyde,
		tetra,
		octa,
		hexi
	} memsz_t;

endpackage

`default_nettype wire

//--- logic/lsq_pkg.sv
// Load/store queue types
// Command codes for the queue's command slots, the entry record held per
// queue slot, the sequence number and the cache line constants
`default_nettype none

package lsq_pkg;

	// Commands accepted by the queue; NOP means the slot is idle this cycle
	typedef enum logic [2:0] {
		NOP,
		ENQ,
		INV,
		SETADR,
		INCADR,
		SETRES
	} lsq_cmd_e;

	// Relative age of an entry, counting down from the newest
	typedef logic [6:0] seqnum_t;
	localparam seqnum_t SN_NEW = 7'd127;

	// Cache line geometry
	localparam int LINE_BYTES = 64;
	localparam int LINE_OFS_W = $clog2(LINE_BYTES);

	// Byte shift that aligns data within a line holds any value from 0 to 64
	typedef logic [6:0] shift_t;

	// Progress of an access that may span two lines
	typedef logic [1:0] lsq_state_t;
	localparam lsq_state_t ST_FIRST = 2'b00;
	localparam lsq_state_t ST_LINE2 = 2'b01;

	// One queue slot
	typedef struct packed {
		logic                    v;
		logic                    agen;
		logic                    load;
		logic                    store;
		logic                    loadv;
		logic                    datav;
		lsq_state_t              state;
		cpu_types_pkg::rob_ndx_t rndx;
		cpu_types_pkg::memsz_t   memsz;
		cpu_types_pkg::vaddr_t   vadr;
		cpu_types_pkg::paddr_t   padr;
		shift_t                  shift;
		shift_t                  shift2;
		cpu_types_pkg::value_t   res;
		seqnum_t                 sn;
	} lsq_entry_t;

endpackage

`default_nettype wire

//--- logic/lsq_cmd_if.sv
// Load/store queue command slot
// Carries one command per cycle from a producer into the queue. A command
// is live only in the cycle where cmd is not NOP and is never stalled
`timescale 1ns/1ps
`default_nettype none

interface lsq_cmd_if #(
	parameter int LSQ_ENTRIES = 8
);
	localparam int SLOT_W = $clog2(LSQ_ENTRIES);

	lsq_pkg::lsq_cmd_e       cmd;
	logic [SLOT_W-1:0]       slot;
	cpu_types_pkg::rob_ndx_t rndx;
	cpu_types_pkg::memsz_t   memsz;
	cpu_types_pkg::vaddr_t   vadr;
	// Store data or load result, or the physical address for SETADR
	cpu_types_pkg::value_t   data;
	logic                    exc;
	logic                    load_op;
	logic                    store_op;

	// Producer side
	modport src(output cmd, slot, rndx, memsz, vadr, data, exc, load_op, store_op);

	// Queue side
	modport snk(input cmd, slot, rndx, memsz, vadr, data, exc, load_op, store_op);

endinterface

`default_nettype wire

//--- logic/lsq_alloc_ctl.sv
// Load/store queue slot allocation
// Tracks head, tail and occupancy, keeps the reorder-buffer-to-slot map
// and turns the enqueue, result and retire strobes into queue commands
`timescale 1ns/1ps
`default_nettype none

module lsq_alloc_ctl #(
	parameter int LSQ_ENTRIES = 8,
	localparam int SLOT_W = $clog2(LSQ_ENTRIES)
) (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          enq,
	input  wire cpu_types_pkg::rob_ndx_t enq_rndx,
	input  wire                          enq_load,
	input  wire                          enq_store,
	input  wire cpu_types_pkg::memsz_t   enq_memsz,
	input  wire cpu_types_pkg::vaddr_t   enq_vadr,
	input  wire                          res,
	input  wire cpu_types_pkg::rob_ndx_t res_rndx,
	input  wire cpu_types_pkg::value_t   res_data,
	input  wire                          ret,
	input  wire                          ret_exc,
	input  wire cpu_types_pkg::rob_ndx_t map_rndx,
	output logic [SLOT_W-1:0]            map_slot,
	output logic                         lsq_full,
	output logic                         lsq_empty,
	lsq_cmd_if.src                       enq_cmd,
	lsq_cmd_if.src                       res_cmd,
	lsq_cmd_if.src                       inv_cmd
);

	typedef logic [SLOT_W-1:0] slot_t;
	typedef logic [SLOT_W:0]   count_t;

	slot_t                   head;
	slot_t                   tail;
	count_t                  count;
	// Which slots hold a live operation, and the rob index owning each one
	logic [LSQ_ENTRIES-1:0]  busy;
	cpu_types_pkg::rob_ndx_t slot_rndx [LSQ_ENTRIES];
	// Slot assigned to each reorder-buffer index
	slot_t                   rob_map [cpu_types_pkg::ROB_ENTRIES];
	logic                    enq_ok;
	logic                    ret_ok;

	assign lsq_full  = (count == count_t'(LSQ_ENTRIES));
	assign lsq_empty = (count == '0);

	// Enqueue while full and retire while empty are dropped here
	assign enq_ok = enq && !lsq_full;
	assign ret_ok = ret && !lsq_empty;

	assign map_slot = rob_map[map_rndx];

	// ========================================================================
	// Control state
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			head        <= '0;
			tail        <= '0;
			count       <= '0;
			busy        <= '0;
			enq_cmd.cmd <= lsq_pkg::NOP;
			res_cmd.cmd <= lsq_pkg::NOP;
			inv_cmd.cmd <= lsq_pkg::NOP;
		end else begin
			enq_cmd.cmd <= enq_ok ? lsq_pkg::ENQ : lsq_pkg::NOP;
			res_cmd.cmd <= res ? lsq_pkg::SETRES : lsq_pkg::NOP;
			inv_cmd.cmd <= ret_ok ? lsq_pkg::INV : lsq_pkg::NOP;
			// Entry count is a power of two so the pointers wrap by themselves
			if (enq_ok) begin
				busy[tail] <= 1'b1;
				tail       <= tail + 1'b1;
			end
			if (ret_ok) begin
				busy[head] <= 1'b0;
				head       <= head + 1'b1;
			end
			count <= count + count_t'(enq_ok) - count_t'(ret_ok);
		end
	end

	// ========================================================================
	// Map and command payloads
	// ========================================================================

	always_ff @(posedge clk) begin
		if (enq_ok) begin
			rob_map[enq_rndx] <= tail;
			slot_rndx[tail]   <= enq_rndx;
		end
		enq_cmd.slot     <= tail;
		enq_cmd.rndx     <= enq_rndx;
		enq_cmd.memsz    <= enq_memsz;
		enq_cmd.vadr     <= enq_vadr;
		enq_cmd.load_op  <= enq_load;
		enq_cmd.store_op <= enq_store;
		res_cmd.slot     <= rob_map[res_rndx];
		res_cmd.rndx     <= res_rndx;
		res_cmd.data     <= res_data;
		// Retirement always takes the oldest slot
		inv_cmd.slot     <= head;
		inv_cmd.rndx     <= slot_rndx[head];
		inv_cmd.exc      <= ret_exc;
	end

	// Fields that a given command does not use are held at zero
	assign enq_cmd.data     = '0;
	assign enq_cmd.exc      = 1'b0;
	assign res_cmd.memsz    = cpu_types_pkg::byt;
	assign res_cmd.vadr     = '0;
	assign res_cmd.exc      = 1'b0;
	assign res_cmd.load_op  = 1'b0;
	assign res_cmd.store_op = 1'b0;
	assign inv_cmd.memsz    = cpu_types_pkg::byt;
	assign inv_cmd.vadr     = '0;
	assign inv_cmd.data     = '0;
	assign inv_cmd.load_op  = 1'b0;
	assign inv_cmd.store_op = 1'b0;

	// A rob index must not be handed a new slot while its old slot is still
	// live, unless that old slot is retiring in the same cycle
	map_no_overwrite: assert property (@(posedge clk) disable iff (rst)
		enq_ok && !(ret_ok && rob_map[enq_rndx] == head) |->
			!(busy[rob_map[enq_rndx]] && slot_rndx[rob_map[enq_rndx]] == enq_rndx))
		else $error("lsq_alloc_ctl: live map entry for rob %0d overwritten", enq_rndx);

endmodule

`default_nettype wire

//--- logic/lsq_agen.sv
// Load/store queue address stage
// Merges the translated page number with the entry's page offset into a
// SETADR command, and follows an access that runs past the end of its
// cache line with an INCADR so that the next line is translated too
`timescale 1ns/1ps
`default_nettype none

module lsq_agen #(
	parameter int LSQ_ENTRIES = 8,
	localparam int SLOT_W = $clog2(LSQ_ENTRIES)
) (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          agen,
	input  wire cpu_types_pkg::rob_ndx_t agen_rndx,
	input  wire cpu_types_pkg::ppn_t     agen_ppn,
	output cpu_types_pkg::rob_ndx_t      map_rndx,
	input  wire logic [SLOT_W-1:0]       map_slot,
	output logic [SLOT_W-1:0]            rd_slot,
	input  wire lsq_pkg::lsq_entry_t     rd_entry,
	lsq_cmd_if.src                       agen_cmd
);

	// IDLE issues SETADR on demand, LINE2 owes an INCADR for the last slot
	typedef enum logic {
		AG_IDLE,
		AG_LINE2
	} agen_state_e;

	agen_state_e                    state;
	cpu_types_pkg::paddr_t          padr;
	logic [lsq_pkg::LINE_OFS_W-1:0] line_ofs;
	lsq_pkg::shift_t                acc_bytes;
	logic                           crosses;

	// Rob index to slot, then slot to entry, all in the strobe cycle
	assign map_rndx = agen_rndx;
	assign rd_slot  = map_slot;

	assign padr = {agen_ppn, rd_entry.vadr[cpu_types_pkg::PAGE_OFS_W-1:0]};

	// Only the first part of an access can spill into the next line
	assign line_ofs  = rd_entry.vadr[lsq_pkg::LINE_OFS_W-1:0];
	assign acc_bytes = lsq_pkg::shift_t'(1) << rd_entry.memsz;
	assign crosses   = (rd_entry.state == lsq_pkg::ST_FIRST) &&
		(32'(lsq_pkg::shift_t'(line_ofs) + acc_bytes) > lsq_pkg::LINE_BYTES);

	// ========================================================================
	// Command sequencing
	// ========================================================================

	// The core holds off agen for the cycle in which INCADR goes out
	always_ff @(posedge clk) begin
		if (rst) begin
			state        <= AG_IDLE;
			agen_cmd.cmd <= lsq_pkg::NOP;
		end else if (state == AG_LINE2) begin
			state        <= AG_IDLE;
			agen_cmd.cmd <= lsq_pkg::INCADR;
		end else if (agen) begin
			state        <= crosses ? AG_LINE2 : AG_IDLE;
			agen_cmd.cmd <= lsq_pkg::SETADR;
		end else begin
			agen_cmd.cmd <= lsq_pkg::NOP;
		end
	end

	// Payload is captured with SETADR and reused as is by the INCADR
	always_ff @(posedge clk) begin
		if (agen && state == AG_IDLE) begin
			agen_cmd.slot  <= map_slot;
			agen_cmd.rndx  <= agen_rndx;
			agen_cmd.memsz <= rd_entry.memsz;
			agen_cmd.vadr  <= rd_entry.vadr;
			agen_cmd.data  <= cpu_types_pkg::value_t'(padr);
		end
	end

	assign agen_cmd.exc      = 1'b0;
	assign agen_cmd.load_op  = 1'b0;
	assign agen_cmd.store_op = 1'b0;

	// Translation only ever completes for an operation that holds a slot
	agen_on_valid: assert property (@(posedge clk) disable iff (rst)
		agen |-> rd_entry.v)
		else $error("lsq_agen: agen for rob %0d hits invalid slot %0d", agen_rndx, map_slot);

endmodule

`default_nettype wire

//--- logic/lsq_queue.sv
// Load/store queue storage
// Holds one entry per slot and applies the commands arriving on the four
// command slots. Two combinational read ports serve the address stage and
// the peek port of the top level
`timescale 1ns/1ps
`default_nettype none

module lsq_queue #(
	parameter int LSQ_ENTRIES = 8,
	localparam int SLOT_W = $clog2(LSQ_ENTRIES)
) (
	input  wire                    clk,
	input  wire                    rst,
	lsq_cmd_if.snk                 enq_cmd,
	lsq_cmd_if.snk                 agen_cmd,
	lsq_cmd_if.snk                 res_cmd,
	lsq_cmd_if.snk                 inv_cmd,
	input  wire logic [SLOT_W-1:0] rd_slot,
	output lsq_pkg::lsq_entry_t    rd_entry,
	input  wire logic [SLOT_W-1:0] peek_slot,
	output lsq_pkg::lsq_entry_t    peek_entry
);

	localparam int NCMD = 4;

	typedef logic [SLOT_W-1:0] slot_t;

	// One command in flat form, so all ports go through the same decoder
	typedef struct packed {
		lsq_pkg::lsq_cmd_e       cmd;
		slot_t                   slot;
		cpu_types_pkg::rob_ndx_t rndx;
		cpu_types_pkg::memsz_t   memsz;
		cpu_types_pkg::vaddr_t   vadr;
		cpu_types_pkg::value_t   data;
		logic                    exc;
		logic                    load_op;
		logic                    store_op;
	} cmd_t;

	lsq_pkg::lsq_entry_t lsq [LSQ_ENTRIES];
	cmd_t                c [NCMD];
	logic                slot_clash;

	assign c[0] = '{enq_cmd.cmd, enq_cmd.slot, enq_cmd.rndx, enq_cmd.memsz,
		enq_cmd.vadr, enq_cmd.data, enq_cmd.exc, enq_cmd.load_op, enq_cmd.store_op};
	assign c[1] = '{agen_cmd.cmd, agen_cmd.slot, agen_cmd.rndx, agen_cmd.memsz,
		agen_cmd.vadr, agen_cmd.data, agen_cmd.exc, agen_cmd.load_op, agen_cmd.store_op};
	assign c[2] = '{res_cmd.cmd, res_cmd.slot, res_cmd.rndx, res_cmd.memsz,
		res_cmd.vadr, res_cmd.data, res_cmd.exc, res_cmd.load_op, res_cmd.store_op};
	assign c[3] = '{inv_cmd.cmd, inv_cmd.slot, inv_cmd.rndx, inv_cmd.memsz,
		inv_cmd.vadr, inv_cmd.data, inv_cmd.exc, inv_cmd.load_op, inv_cmd.store_op};

	assign rd_entry   = lsq[rd_slot];
	assign peek_entry = lsq[peek_slot];

	// ========================================================================
	// Command decoder
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < LSQ_ENTRIES; i++)
				lsq[i] <= '0;
		end else begin
			for (int n = 0; n < NCMD; n++) begin
				case (c[n].cmd)
				lsq_pkg::ENQ: begin
					// Every older entry ages by one, the new one starts at the top
					for (int i = 0; i < LSQ_ENTRIES; i++)
						lsq[i].sn <= lsq[i].sn - 1'b1;
					// Clearing also leaves agen, loadv and state at zero
					lsq[c[n].slot]       <= '0;
					lsq[c[n].slot].v     <= 1'b1;
					lsq[c[n].slot].rndx  <= c[n].rndx;
					lsq[c[n].slot].load  <= c[n].load_op;
					lsq[c[n].slot].store <= c[n].store_op;
					lsq[c[n].slot].memsz <= c[n].memsz;
					lsq[c[n].slot].vadr  <= c[n].vadr;
					lsq[c[n].slot].sn    <= lsq_pkg::SN_NEW;
				end
				lsq_pkg::SETADR: begin
					lsq[c[n].slot].agen <= 1'b1;
					lsq[c[n].slot].padr <= cpu_types_pkg::paddr_t'(c[n].data);
					// Line alignment comes from the first part only
					if (lsq[c[n].slot].state == lsq_pkg::ST_FIRST) begin
						lsq[c[n].slot].shift  <=
							lsq_pkg::shift_t'(c[n].data[lsq_pkg::LINE_OFS_W-1:0]);
						lsq[c[n].slot].shift2 <= lsq_pkg::shift_t'(lsq_pkg::LINE_BYTES) -
							lsq_pkg::shift_t'(c[n].data[lsq_pkg::LINE_OFS_W-1:0]);
					end
				end
				lsq_pkg::INCADR: begin
					// Drop agen so the next line goes through translation again
					lsq[c[n].slot].agen  <= 1'b0;
					lsq[c[n].slot].vadr  <= (lsq[c[n].slot].vadr &
						~cpu_types_pkg::vaddr_t'(lsq_pkg::LINE_BYTES - 1)) +
						cpu_types_pkg::vaddr_t'(lsq_pkg::LINE_BYTES);
					lsq[c[n].slot].state <= lsq_pkg::ST_LINE2;
				end
				lsq_pkg::SETRES: begin
					lsq[c[n].slot].res   <= c[n].data;
					lsq[c[n].slot].datav <= 1'b1;
				end
				lsq_pkg::INV: begin
					lsq[c[n].slot].v     <= 1'b0;
					lsq[c[n].slot].agen  <= 1'b0;
					lsq[c[n].slot].datav <= 1'b0;
					lsq[c[n].slot].load  <= 1'b0;
					lsq[c[n].slot].store <= 1'b0;
					lsq[c[n].slot].state <= lsq_pkg::ST_FIRST;
					// res stays behind as cached load data if the load was clean
					lsq[c[n].slot].loadv <= lsq[c[n].slot].load && !c[n].exc &&
						(lsq[c[n].slot].memsz inside {cpu_types_pkg::byt,
						cpu_types_pkg::wyde, cpu_types_pkg::tetra, cpu_types_pkg::octa});
				end
				default: ;
				endcase
			end
		end
	end

	// Producers must never aim two commands at one slot in the same cycle
	always_comb begin
		slot_clash = 1'b0;
		for (int a = 0; a < NCMD - 1; a++)
			for (int b = a + 1; b < NCMD; b++)
				if (c[a].cmd != lsq_pkg::NOP && c[b].cmd != lsq_pkg::NOP &&
					c[a].slot == c[b].slot)
					slot_clash = 1'b1;
	end

	one_cmd_per_slot: assert property (@(posedge clk) disable iff (rst) !slot_clash)
		else $error("lsq_queue: two commands target one slot in the same cycle");

endmodule

`default_nettype wire

//--- logic/lsq_unit.sv
// Load/store queue subsystem
// Connects slot allocation, the address stage and the queue storage
// through four command slots, and exposes a peek port and status levels
`timescale 1ns/1ps
`default_nettype none

module lsq_unit #(
	parameter int LSQ_ENTRIES = 8,
	localparam int SLOT_W = $clog2(LSQ_ENTRIES)
) (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          enq,
	input  wire cpu_types_pkg::rob_ndx_t enq_rndx,
	input  wire                          enq_load,
	input  wire                          enq_store,
	input  wire cpu_types_pkg::memsz_t   enq_memsz,
	input  wire cpu_types_pkg::vaddr_t   enq_vadr,
	input  wire                          agen,
	input  wire cpu_types_pkg::rob_ndx_t agen_rndx,
	input  wire cpu_types_pkg::ppn_t     agen_ppn,
	input  wire                          res,
	input  wire cpu_types_pkg::rob_ndx_t res_rndx,
	input  wire cpu_types_pkg::value_t   res_data,
	input  wire                          ret,
	input  wire                          ret_exc,
	input  wire logic [SLOT_W-1:0]       peek_slot,
	output lsq_pkg::lsq_entry_t          peek_entry,
	output logic                         lsq_full,
	output logic                         lsq_empty
);

	cpu_types_pkg::rob_ndx_t map_rndx;
	logic [SLOT_W-1:0]       map_slot;
	logic [SLOT_W-1:0]       rd_slot;
	lsq_pkg::lsq_entry_t     rd_entry;

	lsq_cmd_if #(.LSQ_ENTRIES(LSQ_ENTRIES)) enq_cmd ();
	lsq_cmd_if #(.LSQ_ENTRIES(LSQ_ENTRIES)) res_cmd ();
	lsq_cmd_if #(.LSQ_ENTRIES(LSQ_ENTRIES)) inv_cmd ();
	lsq_cmd_if #(.LSQ_ENTRIES(LSQ_ENTRIES)) agen_cmd ();

	lsq_alloc_ctl #(.LSQ_ENTRIES(LSQ_ENTRIES)) u_alloc (
		.clk, .rst,
		.enq, .enq_rndx, .enq_load, .enq_store, .enq_memsz, .enq_vadr,
		.res, .res_rndx, .res_data,
		.ret, .ret_exc,
		.map_rndx, .map_slot,
		.lsq_full, .lsq_empty,
		.enq_cmd, .res_cmd, .inv_cmd
	);

	lsq_agen #(.LSQ_ENTRIES(LSQ_ENTRIES)) u_agen (
		.clk, .rst,
		.agen, .agen_rndx, .agen_ppn,
		.map_rndx, .map_slot,
		.rd_slot, .rd_entry,
		.agen_cmd
	);

	lsq_queue #(.LSQ_ENTRIES(LSQ_ENTRIES)) u_queue (
		.clk, .rst,
		.enq_cmd, .agen_cmd, .res_cmd, .inv_cmd,
		.rd_slot, .rd_entry,
		.peek_slot, .peek_entry
	);

endmodule

`default_nettype wire

//--- bench/lsq_unit_tb_checks.svh
// Load/store queue testbench checks
// Concurrent assertions on the peek port and on the full and empty levels,
// compared against the reference state kept by the testbench
`ifndef LSQ_UNIT_TB_CHECKS_SVH
`define LSQ_UNIT_TB_CHECKS_SVH
`default_nettype none

	// Peeked slot must match the reference entry while a check is armed
	peek_match: assert property (@(posedge clk) disable iff (rst)
		chk_on |-> peek_entry == exp_entry)
		else begin
			err_cnt++;
			$display("CHECK FAILED at %0t: peek_entry[%0d] expected %h got %h", $time,
				$sampled(peek_slot), $sampled(exp_entry), $sampled(peek_entry));
		end

	// Levels follow the occupancy one edge after the strobe was sampled
	full_level: assert property (@(posedge clk) disable iff (rst)
		lsq_full == (count_seen == LSQ_ENTRIES))
		else begin
			err_cnt++;
			$display("CHECK FAILED at %0t: lsq_full expected %0b got %0b", $time,
				$sampled(count_seen) == LSQ_ENTRIES, $sampled(lsq_full));
		end

	empty_level: assert property (@(posedge clk) disable iff (rst)
		lsq_empty == (count_seen == 0))
		else begin
			err_cnt++;
			$display("CHECK FAILED at %0t: lsq_empty expected %0b got %0b", $time,
				$sampled(count_seen) == 0, $sampled(lsq_empty));
		end

`default_nettype wire
`endif

//--- bench/lsq_unit_tb.sv
// Load/store queue testbench
// Drives enqueue, address, result and retire strobes into the subsystem,
// keeps a reference copy of every slot and checks it through the peek port
`timescale 1ns/1ps
`default_nettype none

module lsq_unit_tb;

	localparam int LSQ_ENTRIES = 8;
	localparam int SLOT_W      = $clog2(LSQ_ENTRIES);
	localparam int CLK_PERIOD  = 40;
	// Cycle budget of the reset, fill, address, result, retire and crossing tests
	localparam int RUN_CYCLES  = (4 + LSQ_ENTRIES) + (5 * LSQ_ENTRIES + 8) +
		4 * LSQ_ENTRIES + 3 * LSQ_ENTRIES + 3 * LSQ_ENTRIES + 60;
	localparam int WATCHDOG_NS = 2 * RUN_CYCLES * CLK_PERIOD;

	logic                    clk;
	logic                    rst;
	logic                    enq;
	cpu_types_pkg::rob_ndx_t enq_rndx;
	logic                    enq_load;
	logic                    enq_store;
	cpu_types_pkg::memsz_t   enq_memsz;
	cpu_types_pkg::vaddr_t   enq_vadr;
	logic                    agen;
	cpu_types_pkg::rob_ndx_t agen_rndx;
	cpu_types_pkg::ppn_t     agen_ppn;
	logic                    res;
	cpu_types_pkg::rob_ndx_t res_rndx;
	cpu_types_pkg::value_t   res_data;
	logic                    ret;
	logic                    ret_exc;
	logic [SLOT_W-1:0]       peek_slot;
	lsq_pkg::lsq_entry_t     peek_entry;
	logic                    lsq_full;
	logic                    lsq_empty;

	// Reference queue state built from the queue rules
	lsq_pkg::lsq_entry_t     model [LSQ_ENTRIES];
	logic [SLOT_W-1:0]       slot_of [cpu_types_pkg::ROB_ENTRIES];
	logic [SLOT_W-1:0]       head_m;
	logic [SLOT_W-1:0]       tail_m;
	cpu_types_pkg::rob_ndx_t rob_next;
	int                      exp_count;
	int                      count_seen;
	lsq_pkg::lsq_entry_t     exp_entry;
	logic                    chk_on;
	int                      err_cnt;
	int                      err_base;
	int                      chk_cnt;
	int                      test_cnt;

	lsq_unit #(.LSQ_ENTRIES(LSQ_ENTRIES)) u_dut (.*);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// Occupancy as the DUT should show it after the sampling edge
	always @(posedge clk) count_seen <= exp_count;

	// ========================================================================
	// Stimulus tasks
	// ========================================================================

	task automatic step(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	// Arm the peek check on one slot for a number of edges
	task automatic check_slot(input int slot, input int hold);
		peek_slot = SLOT_W'(slot);
		exp_entry = model[slot];
		chk_on    = 1'b1;
		chk_cnt  += hold;
		step(hold);
		chk_on    = 1'b0;
	endtask

	task automatic end_test(input string name);
		test_cnt++;
		$display("Test %0d %s: %0d failures", test_cnt, name, err_cnt - err_base);
		err_base = err_cnt;
	endtask

	task automatic push_entry(input logic load, input cpu_types_pkg::memsz_t memsz,
		input cpu_types_pkg::vaddr_t vadr);
		enq       = 1'b1;
		enq_rndx  = rob_next;
		enq_load  = load;
		enq_store = !load;
		enq_memsz = memsz;
		enq_vadr  = vadr;
		// A full queue drops the request and every slot stays as it was
		if (exp_count < LSQ_ENTRIES) begin
			for (int i = 0; i < LSQ_ENTRIES; i++)
				model[i].sn = model[i].sn - 7'd1;
			model[tail_m]       = '0;
			model[tail_m].v     = 1'b1;
			model[tail_m].rndx  = rob_next;
			model[tail_m].load  = load;
			model[tail_m].store = !load;
			model[tail_m].memsz = memsz;
			model[tail_m].vadr  = vadr;
			model[tail_m].sn    = 7'd127;
			slot_of[rob_next]   = tail_m;
			tail_m++;
			exp_count++;
			rob_next++;
		end
		step(1);
		enq = 1'b0;
	endtask

	task automatic translate_entry(input cpu_types_pkg::rob_ndx_t rndx,
		input cpu_types_pkg::ppn_t ppn, output logic crossed);
		logic [SLOT_W-1:0]   s;
		lsq_pkg::lsq_entry_t e;
		int                  ofs;
		int                  size;
		s       = slot_of[rndx];
		e       = model[s];
		ofs     = int'(e.vadr[5:0]);
		size    = 1 << int'(e.memsz);
		crossed = 1'b0;
		e.agen  = 1'b1;
		e.padr  = {ppn, e.vadr[11:0]};
		// Only the first part sets the shifts and may spill into the next line
		if (e.state == 2'b00) begin
			e.shift  = 7'(ofs);
			e.shift2 = 7'(64 - ofs);
			if (ofs + size > 64) begin
				crossed = 1'b1;
				e.agen  = 1'b0;
				e.vadr  = {e.vadr[31:6], 6'd0} + 32'd64;
				e.state = 2'b01;
			end
		end
		model[s]  = e;
		agen      = 1'b1;
		agen_rndx = rndx;
		agen_ppn  = ppn;
		step(1);
		agen = 1'b0;
	endtask

	task automatic write_result(input cpu_types_pkg::rob_ndx_t rndx,
		input cpu_types_pkg::value_t data);
		model[slot_of[rndx]].res   = data;
		model[slot_of[rndx]].datav = 1'b1;
		res      = 1'b1;
		res_rndx = rndx;
		res_data = data;
		step(1);
		res = 1'b0;
	endtask

	task automatic retire_head(input logic exc, output logic [SLOT_W-1:0] slot);
		slot    = head_m;
		ret     = 1'b1;
		ret_exc = exc;
		if (exp_count > 0) begin
			// Clean loads up to eight bytes stay behind as load data
			model[head_m].loadv = model[head_m].load && !exc &&
				(model[head_m].memsz != cpu_types_pkg::hexi);
			model[head_m].v     = 1'b0;
			model[head_m].agen  = 1'b0;
			model[head_m].datav = 1'b0;
			model[head_m].load  = 1'b0;
			model[head_m].store = 1'b0;
			model[head_m].state = 2'b00;
			head_m++;
			exp_count--;
		end
		step(1);
		ret = 1'b0;
	endtask

	// ========================================================================
	// Test sequence
	// ========================================================================

	initial begin
		logic [SLOT_W-1:0]     s;
		logic                  crossed;
		cpu_types_pkg::memsz_t msz;
		cpu_types_pkg::vaddr_t va;
		void'($urandom(32'hbd929701));
		{enq, enq_load, enq_store, agen, res, ret, ret_exc, chk_on} = '0;
		enq_rndx  = '0;
		enq_memsz = cpu_types_pkg::byt;
		enq_vadr  = '0;
		agen_rndx = '0;
		agen_ppn  = '0;
		res_rndx  = '0;
		res_data  = '0;
		peek_slot = '0;
		exp_entry = '0;
		for (int i = 0; i < LSQ_ENTRIES; i++)
			model[i] = '0;
		for (int i = 0; i < cpu_types_pkg::ROB_ENTRIES; i++)
			slot_of[i] = '0;
		{head_m, tail_m, rob_next} = '0;
		{exp_count, count_seen, err_cnt, err_base, chk_cnt, test_cnt} = '0;
		rst = 1'b1;
		step(4);
		rst = 1'b0;

		for (int i = 0; i < LSQ_ENTRIES; i++)
			check_slot(i, 1);
		end_test("reset");

		// Sizes walk through all codes and addresses are aligned so nothing crosses
		for (int i = 0; i < LSQ_ENTRIES; i++) begin
			s   = tail_m;
			msz = cpu_types_pkg::memsz_t'(i % 5);
			va  = $urandom() & ~((32'd1 << (i % 5)) - 32'd1);
			push_entry((i % 2 == 0) || (i == 3), msz, va);
			step(1);
			check_slot(s, 1);
		end
		for (int i = 0; i < LSQ_ENTRIES; i++)
			check_slot(i, 1);
		push_entry(1'b1, cpu_types_pkg::octa, $urandom());
		step(1);
		for (int i = 0; i < LSQ_ENTRIES; i++)
			check_slot(i, 1);
		end_test("enqueue");

		for (int i = 0; i < LSQ_ENTRIES; i++) begin
			translate_entry(model[i].rndx, cpu_types_pkg::ppn_t'($urandom()), crossed);
			step(crossed ? 2 : 1);
			check_slot(i, 2);
		end
		end_test("address");

		for (int i = 0; i < LSQ_ENTRIES; i++) begin
			write_result(model[i].rndx, {$urandom(), $urandom()});
			step(1);
			check_slot(i, 1);
		end
		end_test("result");

		for (int i = 0; i < LSQ_ENTRIES; i++) begin
			retire_head((i == 2) || (i == 5), s);
			step(1);
			check_slot(s, 1);
		end
		step(2);
		end_test("retire");

		// Offset 60 with eight bytes runs into the next line
		s  = tail_m;
		va = $urandom();
		push_entry(1'b1, cpu_types_pkg::octa, {va[31:6], 6'd60});
		step(1);
		translate_entry(model[s].rndx, cpu_types_pkg::ppn_t'($urandom()), crossed);
		step(crossed ? 2 : 1);
		check_slot(s, 1);
		translate_entry(model[s].rndx, cpu_types_pkg::ppn_t'($urandom()), crossed);
		step(1);
		check_slot(s, 1);
		for (int k = 0; k < 3; k++) begin
			s   = tail_m;
			msz = cpu_types_pkg::memsz_t'($urandom_range(4, 0));
			push_entry(1'b0, msz, $urandom());
			step(1);
			translate_entry(model[s].rndx, cpu_types_pkg::ppn_t'($urandom()), crossed);
			step(crossed ? 2 : 1);
			check_slot(s, 1);
		end
		while (exp_count > 0) begin
			retire_head(1'b0, s);
			step(1);
			check_slot(s, 1);
		end
		step(2);
		end_test("line crossing");

		$display("Tests run: %0d, checks: %0d, failures: %0d", test_cnt, chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
		$display("Some tests failed");
		$finish;
	end

	`include "lsq_unit_tb_checks.svh"

endmodule

`default_nettype wire

//--- lsq_unit.f
+incdir+bench
logic/cpu_types_pkg.sv
logic/lsq_pkg.sv
logic/lsq_cmd_if.sv
logic/lsq_alloc_ctl.sv
logic/lsq_agen.sv
logic/lsq_queue.sv
logic/lsq_unit.sv
bench/lsq_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module lsq_unit_tb -f lsq_unit.f -o lsq_unit_sim

out=$(./obj_dir/lsq_unit_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "All tests passed"; then
	exit 0
else
	exit 1
fi
